//--- rtl/bench_pkg.sv
// TCP benchmark shared types
// widths, status fields, controller states

package bench_pkg;

  // totals and budgets
  typedef logic [47:0] bytes_t;   // byte total
  typedef logic [31:0] count_t;   // packet or status-word count
  typedef logic [63:0] cycles_t;  // run budget, elapsed cycles

  // status words from the TCP stack
  typedef logic [23:0] open_sts_t;  // open-connection reply
  typedef logic [63:0] tx_sts_t;    // transmit status

  // high on a successful open
  localparam int OPEN_SUCCESS_BIT = 16;

  // two-bit error field of the tx status word, zero when good
  localparam int TX_STS_ERR_HI = 63;
  localparam int TX_STS_ERR_LO = 62;

  // run controller
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,  // waiting for a command
    ST_RUN  = 2'd1,  // measuring
    ST_DONE = 2'd2   // holding result for the host
  } run_state_e;

endpackage

//--- rtl/stream_tap_if.sv
// Data stream handshake tap

`timescale 1ns/10ps

interface stream_tap_if #(
  parameter int STREAM_BYTES = 8
) ();

  logic                    valid;
  logic                    ready;
  logic [STREAM_BYTES-1:0] keep;   // one bit per byte lane
  logic                    last;   // end of packet

  // top level fills the tap from its ports
  modport drive (output valid, ready, keep, last);

  // counters only watch
  modport mon (input valid, ready, keep, last);

endinterface

//--- rtl/run_ctrl_fsm.sv
// Run control FSM

`timescale 1ns/10ps

module run_ctrl_fsm
  import bench_pkg::*;
(
  input  logic ap_clk,
  input  logic ap_rst_n,
  input  logic cmd_valid,
  output logic cmd_ready,
  output logic result_valid,
  input  logic result_ready,
  input  logic expired,
  output logic start,
  output logic busy
);

  run_state_e state_q;
  run_state_e state_d;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid) begin
          state_d = ST_RUN;  // command accepted
        end
      end
      ST_RUN: begin
        if (expired) begin
          state_d = ST_DONE;  // budget used up
        end
      end
      ST_DONE: begin
        if (result_ready) begin
          state_d = ST_IDLE;  // host took the totals
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign cmd_ready    = (state_q == ST_IDLE);
  assign busy         = (state_q == ST_RUN);
  assign result_valid = (state_q == ST_DONE);

  // one-cycle pulse, clears counters and loads the timer
  assign start = cmd_valid & cmd_ready;

  // the timer may only fire while a run is in progress
  a_expired_in_run : assert property (
    @(posedge ap_clk) disable iff (!ap_rst_n)
    expired |-> (state_q == ST_RUN)
  );

endmodule

//--- rtl/run_timer.sv
// Run cycle budget timer

`timescale 1ns/10ps

module run_timer
  import bench_pkg::*;
(
  input  logic    ap_clk,
  input  logic    ap_rst_n,
  input  logic    start,
  input  cycles_t load_cycles,
  input  logic    busy,
  output logic    expired
);

  cycles_t remaining;  // cycles left in the run

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      remaining <= '0;
    end else if (start) begin
      remaining <= load_cycles;
    end else if (busy) begin
      remaining <= remaining - cycles_t'(1);
    end
  end

  // last busy cycle of the budget
  assign expired = busy && (remaining == cycles_t'(1));

  // a zero budget would never expire
  a_nonzero_load : assert property (
    @(posedge ap_clk) disable iff (!ap_rst_n)
    start |-> (load_cycles != '0)
  );

endmodule

//--- rtl/stream_byte_counter.sv
// Stream byte and packet counter

`timescale 1ns/10ps

module stream_byte_counter
  import bench_pkg::*;
#(
  parameter int STREAM_BYTES = 8
) (
  input  logic             ap_clk,
  input  logic             ap_rst_n,
  stream_tap_if.mon        tap,
  input  logic             clear,
  input  logic             count_en,
  output bytes_t           byte_total,
  output count_t           pkt_total
);

  localparam int KW = $clog2(STREAM_BYTES + 1);  // width of a per-beat byte count

  logic          beat;        // counted handshake
  logic [KW-1:0] beat_bytes;  // set bits of keep

  assign beat = tap.valid & tap.ready & count_en;

  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < STREAM_BYTES; i++) begin
      beat_bytes = beat_bytes + KW'(tap.keep[i]);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n || clear) begin
      byte_total <= '0;
      pkt_total  <= '0;
    end else if (beat) begin
      byte_total <= byte_total + bytes_t'(beat_bytes);
      if (tap.last) begin
        pkt_total <= pkt_total + count_t'(1);
      end
    end
  end

  // popcount is only a byte count when lanes fill from bit 0
  a_keep_contiguous : assert property (
    @(posedge ap_clk) disable iff (!ap_rst_n)
    beat |-> ((tap.keep != '0) && ((tap.keep & (tap.keep + 1'b1)) == '0))
  );

endmodule

//--- rtl/session_status_counter.sv
// Open reply and tx status counters

`timescale 1ns/10ps

module session_status_counter
  import bench_pkg::*;
(
  input  logic      ap_clk,
  input  logic      ap_rst_n,
  input  logic      clear,
  input  logic      count_en,
  input  logic      open_valid,
  input  logic      open_ready,
  input  open_sts_t open_data,
  input  logic      txs_valid,
  input  logic      txs_ready,
  input  tx_sts_t   txs_data,
  output count_t    open_total,
  output count_t    open_success,
  output count_t    txs_total,
  output count_t    txs_good
);

  logic open_beat;  // counted open reply
  logic txs_beat;   // counted tx status word

  assign open_beat = open_valid & open_ready & count_en;
  assign txs_beat  = txs_valid & txs_ready & count_en;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n || clear) begin
      open_total   <= '0;
      open_success <= '0;
      txs_total    <= '0;
      txs_good     <= '0;
    end else begin
      if (open_beat) begin
        open_total <= open_total + count_t'(1);
        if (open_data[OPEN_SUCCESS_BIT]) begin
          open_success <= open_success + count_t'(1);
        end
      end
      if (txs_beat) begin
        txs_total <= txs_total + count_t'(1);
        if (txs_data[TX_STS_ERR_HI:TX_STS_ERR_LO] == 2'b00) begin
          txs_good <= txs_good + count_t'(1);  // no error reported
        end
      end
    end
  end

endmodule

//--- rtl/bench_top.sv
// TCP throughput measurement core
// run control, timer and traffic counters

`timescale 1ns/10ps

module bench_top
  import bench_pkg::*;
#(
  parameter int STREAM_BYTES = 8
) (
  input  logic                    ap_clk,
  input  logic                    ap_rst_n,
  // host command and result
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  cycles_t                 cmd_cycles,
  output logic                    result_valid,
  input  logic                    result_ready,
  // observed data streams
  input  logic                    rx_tvalid,
  input  logic                    rx_tready,
  input  logic [STREAM_BYTES-1:0] rx_tkeep,
  input  logic                    rx_tlast,
  input  logic                    tx_tvalid,
  input  logic                    tx_tready,
  input  logic [STREAM_BYTES-1:0] tx_tkeep,
  input  logic                    tx_tlast,
  // observed status streams
  input  logic                    open_sts_tvalid,
  input  logic                    open_sts_tready,
  input  open_sts_t               open_sts_tdata,
  input  logic                    tx_sts_tvalid,
  input  logic                    tx_sts_tready,
  input  tx_sts_t                 tx_sts_tdata,
  // totals
  output logic                    busy,
  output bytes_t                  rx_bytes,
  output count_t                  rx_pkts,
  output bytes_t                  tx_bytes,
  output count_t                  tx_pkts,
  output count_t                  open_total,
  output count_t                  open_success,
  output count_t                  tx_sts_total,
  output count_t                  tx_sts_good
);

  logic start;    // command accept pulse
  logic expired;  // last cycle of the run

  stream_tap_if #(.STREAM_BYTES(STREAM_BYTES)) rx_tap ();
  stream_tap_if #(.STREAM_BYTES(STREAM_BYTES)) tx_tap ();

  assign rx_tap.valid = rx_tvalid;
  assign rx_tap.ready = rx_tready;
  assign rx_tap.keep  = rx_tkeep;
  assign rx_tap.last  = rx_tlast;

  assign tx_tap.valid = tx_tvalid;
  assign tx_tap.ready = tx_tready;
  assign tx_tap.keep  = tx_tkeep;
  assign tx_tap.last  = tx_tlast;

  run_ctrl_fsm u_ctrl (
    .ap_clk       (ap_clk),
    .ap_rst_n     (ap_rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .expired      (expired),
    .start        (start),
    .busy         (busy)
  );

  run_timer u_timer (
    .ap_clk      (ap_clk),
    .ap_rst_n    (ap_rst_n),
    .start       (start),
    .load_cycles (cmd_cycles),
    .busy        (busy),
    .expired     (expired)
  );

  stream_byte_counter #(.STREAM_BYTES(STREAM_BYTES)) u_rx_cnt (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .tap        (rx_tap.mon),
    .clear      (start),
    .count_en   (busy),
    .byte_total (rx_bytes),
    .pkt_total  (rx_pkts)
  );

  stream_byte_counter #(.STREAM_BYTES(STREAM_BYTES)) u_tx_cnt (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .tap        (tx_tap.mon),
    .clear      (start),
    .count_en   (busy),
    .byte_total (tx_bytes),
    .pkt_total  (tx_pkts)
  );

  session_status_counter u_sts_cnt (
    .ap_clk       (ap_clk),
    .ap_rst_n     (ap_rst_n),
    .clear        (start),
    .count_en     (busy),
    .open_valid   (open_sts_tvalid),
    .open_ready   (open_sts_tready),
    .open_data    (open_sts_tdata),
    .txs_valid    (tx_sts_tvalid),
    .txs_ready    (tx_sts_tready),
    .txs_data     (tx_sts_tdata),
    .open_total   (open_total),
    .open_success (open_success),
    .txs_total    (tx_sts_total),
    .txs_good     (tx_sts_good)
  );

endmodule

//--- dv/tb_bench_top.sv
// Testbench for the TCP throughput measurement core

`timescale 1ns/10ps

module tb_bench_top
  import bench_pkg::*;
();

  localparam int STREAM_BYTES = 8;
  localparam int WAIT_LIMIT   = 1000;  // cycles before a wait gives up

  logic ap_clk;
  logic ap_rst_n;
  logic cmd_valid;
  logic cmd_ready;
  cycles_t cmd_cycles;
  logic result_valid;
  logic result_ready;
  logic rx_tvalid;
  logic rx_tready;
  logic [STREAM_BYTES-1:0] rx_tkeep;
  logic rx_tlast;
  logic tx_tvalid;
  logic tx_tready;
  logic [STREAM_BYTES-1:0] tx_tkeep;
  logic tx_tlast;
  logic open_sts_tvalid;
  logic open_sts_tready;
  open_sts_t open_sts_tdata;
  logic tx_sts_tvalid;
  logic tx_sts_tready;
  tx_sts_t tx_sts_tdata;
  logic busy;
  bytes_t rx_bytes;
  count_t rx_pkts;
  bytes_t tx_bytes;
  count_t tx_pkts;
  count_t open_total;
  count_t open_success;
  count_t tx_sts_total;
  count_t tx_sts_good;

  integer seed;

  bench_top #(.STREAM_BYTES(STREAM_BYTES)) u_dut (.*);

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;  // 100 ns period
  end

  task automatic check_eq(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  // lanes filled from bit 0
  function automatic logic [STREAM_BYTES-1:0] contiguous_keep(input int lanes);
    return {STREAM_BYTES{1'b1}} >> (STREAM_BYTES - lanes);
  endfunction

  task automatic clear_taps();
    rx_tvalid       = 1'b0;
    rx_tready       = 1'b0;
    rx_tkeep        = '0;
    rx_tlast        = 1'b0;
    tx_tvalid       = 1'b0;
    tx_tready       = 1'b0;
    tx_tkeep        = '0;
    tx_tlast        = 1'b0;
    open_sts_tvalid = 1'b0;
    open_sts_tready = 1'b0;
    open_sts_tdata  = '0;
    tx_sts_tvalid   = 1'b0;
    tx_sts_tready   = 1'b0;
    tx_sts_tdata    = '0;
  endtask

  // returns at the first falling edge with busy high
  task automatic start_run(input cycles_t cycles);
    int n;
    n = 0;
    @(negedge ap_clk);
    cmd_cycles = cycles;
    cmd_valid  = 1'b1;
    while (!busy && n < WAIT_LIMIT) begin
      @(negedge ap_clk);
      n++;
    end
    if (!busy) report_timeout("busy");
    cmd_valid = 1'b0;
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    while (!result_valid && n < WAIT_LIMIT) begin
      @(negedge ap_clk);
      n++;
    end
    if (!result_valid) report_timeout("result_valid");
  endtask

  task automatic take_result();
    result_ready = 1'b1;
    @(negedge ap_clk);
    result_ready = 1'b0;
    check_eq("take_result cmd_ready", 1, cmd_ready);
    check_eq("take_result result_valid", 0, result_valid);
  endtask

  task automatic check_totals_zero(input string name);
    check_eq({name, " rx_bytes"}, 0, rx_bytes);
    check_eq({name, " rx_pkts"}, 0, rx_pkts);
    check_eq({name, " tx_bytes"}, 0, tx_bytes);
    check_eq({name, " tx_pkts"}, 0, tx_pkts);
    check_eq({name, " open_total"}, 0, open_total);
    check_eq({name, " open_success"}, 0, open_success);
    check_eq({name, " tx_sts_total"}, 0, tx_sts_total);
    check_eq({name, " tx_sts_good"}, 0, tx_sts_good);
  endtask

  // random rx beats for as long as the run lasts
  task automatic run_rx_beats(output longint exp_bytes, output longint exp_pkts);
    int lanes;
    int n;
    exp_bytes = 0;
    exp_pkts  = 0;
    n = 0;
    while (busy && n < WAIT_LIMIT) begin
      lanes     = 1 + ({$random(seed)} % STREAM_BYTES);
      rx_tvalid = ($random(seed) % 4) != 0;
      rx_tready = ($random(seed) % 3) != 0;  // stall now and then
      rx_tkeep  = contiguous_keep(lanes);
      rx_tlast  = ($random(seed) % 2) != 0;
      if (rx_tvalid && rx_tready) begin
        exp_bytes += lanes;
        if (rx_tlast) exp_pkts++;
      end
      @(negedge ap_clk);
      n++;
    end
    clear_taps();
  endtask

  task automatic test_reset();
    check_eq("test_reset cmd_ready", 1, cmd_ready);
    check_eq("test_reset busy", 0, busy);
    check_eq("test_reset result_valid", 0, result_valid);
    check_totals_zero("test_reset");
  endtask

  task automatic test_rx_traffic();
    longint exp_bytes;
    longint exp_pkts;
    start_run(64);
    run_rx_beats(exp_bytes, exp_pkts);
    wait_result();
    check_eq("test_rx_traffic rx_bytes", exp_bytes, rx_bytes);
    check_eq("test_rx_traffic rx_pkts", exp_pkts, rx_pkts);
    take_result();
  endtask

  task automatic test_tx_and_status();
    longint exp_bytes;
    longint exp_pkts;
    longint exp_open;
    longint exp_open_ok;
    longint exp_txs;
    longint exp_txs_good;
    int lanes;
    int n;
    exp_bytes    = 0;
    exp_pkts     = 0;
    exp_open     = 0;
    exp_open_ok  = 0;
    exp_txs      = 0;
    exp_txs_good = 0;
    n = 0;
    start_run(80);
    while (busy && n < WAIT_LIMIT) begin
      lanes           = 1 + ({$random(seed)} % STREAM_BYTES);
      tx_tvalid       = ($random(seed) % 4) != 0;
      tx_tready       = ($random(seed) % 3) != 0;
      tx_tkeep        = contiguous_keep(lanes);
      tx_tlast        = ($random(seed) % 2) != 0;
      open_sts_tvalid = ($random(seed) % 3) != 0;
      open_sts_tready = ($random(seed) % 3) != 0;
      open_sts_tdata  = open_sts_t'($random(seed));  // success bit random
      tx_sts_tvalid   = ($random(seed) % 3) != 0;
      tx_sts_tready   = ($random(seed) % 3) != 0;
      tx_sts_tdata    = {$random(seed), $random(seed)};
      if (tx_tvalid && tx_tready) begin
        exp_bytes += lanes;
        if (tx_tlast) exp_pkts++;
      end
      if (open_sts_tvalid && open_sts_tready) begin
        exp_open++;
        if (open_sts_tdata[OPEN_SUCCESS_BIT]) exp_open_ok++;
      end
      if (tx_sts_tvalid && tx_sts_tready) begin
        exp_txs++;
        if (tx_sts_tdata[TX_STS_ERR_HI:TX_STS_ERR_LO] == 2'b00) exp_txs_good++;
      end
      @(negedge ap_clk);
      n++;
    end
    clear_taps();
    wait_result();
    check_eq("test_tx_and_status tx_bytes", exp_bytes, tx_bytes);
    check_eq("test_tx_and_status tx_pkts", exp_pkts, tx_pkts);
    check_eq("test_tx_and_status open_total", exp_open, open_total);
    check_eq("test_tx_and_status open_success", exp_open_ok, open_success);
    check_eq("test_tx_and_status tx_sts_total", exp_txs, tx_sts_total);
    check_eq("test_tx_and_status tx_sts_good", exp_txs_good, tx_sts_good);
    take_result();
  endtask

  task automatic test_duration();
    int busy_cycles;
    busy_cycles = 0;
    start_run(5);
    while (busy && busy_cycles < WAIT_LIMIT) begin
      check_eq("test_duration result_valid in run", 0, result_valid);
      busy_cycles++;
      @(negedge ap_clk);
    end
    check_eq("test_duration busy cycles", 5, busy_cycles);
    check_eq("test_duration result_valid", 1, result_valid);  // same cycle busy fell
    take_result();
  endtask

  task automatic test_backpressure_and_restart();
    longint exp_bytes;
    longint exp_pkts;
    bytes_t held_bytes;
    count_t held_pkts;
    start_run(30);
    run_rx_beats(exp_bytes, exp_pkts);
    wait_result();
    check_eq("test_backpressure rx_bytes", exp_bytes, rx_bytes);
    check_eq("test_backpressure rx_pkts", exp_pkts, rx_pkts);
    held_bytes = rx_bytes;
    held_pkts  = rx_pkts;
    repeat (10) begin
      @(negedge ap_clk);
      check_eq("test_backpressure result_valid", 1, result_valid);
      check_eq("test_backpressure cmd_ready", 0, cmd_ready);
      check_eq("test_backpressure rx_bytes held", held_bytes, rx_bytes);
      check_eq("test_backpressure rx_pkts held", held_pkts, rx_pkts);
    end
    take_result();
    rx_tvalid = 1'b1;  // full beats while idle
    rx_tready = 1'b1;
    rx_tkeep  = '1;
    rx_tlast  = 1'b1;
    repeat (6) @(negedge ap_clk);
    clear_taps();
    check_eq("test_backpressure idle rx_bytes", held_bytes, rx_bytes);
    check_eq("test_backpressure idle rx_pkts", held_pkts, rx_pkts);
    start_run(3);
    wait_result();
    check_totals_zero("test_restart");
    take_result();
  endtask

  initial begin
    seed         = 97267;
    ap_rst_n     = 1'b0;
    cmd_valid    = 1'b0;
    cmd_cycles   = '0;
    result_ready = 1'b0;
    clear_taps();
    repeat (8) @(posedge ap_clk);
    @(negedge ap_clk);
    ap_rst_n = 1'b1;
    test_reset();
    test_rx_traffic();
    test_tx_and_status();
    test_duration();
    test_backpressure_and_restart();
    $display("sim passed");
    $finish;
  end

endmodule

//--- flist.f
rtl/bench_pkg.sv
rtl/stream_tap_if.sv
rtl/run_ctrl_fsm.sv
rtl/run_timer.sv
rtl/stream_byte_counter.sv
rtl/session_status_counter.sv
rtl/bench_top.sv
dv/tb_bench_top.sv
